// File: hsid_pkg.sv
package hsid_pkg;

  localparam int HSID_LANES         = 2;                   // Samples per input word
  localparam int HSID_SAMPLE_WIDTH  = 8;                   // One band sample
  localparam int HSID_WORD_WIDTH    = HSID_LANES * HSID_SAMPLE_WIDTH;
  localparam int HSID_SQ_WIDTH      = 2 * HSID_SAMPLE_WIDTH; // Square of a sample difference
  localparam int HSID_ACC_WIDTH     = 20;                  // Small on purpose, long bright vectors wrap
  localparam int HSID_SUM_WIDTH     = HSID_ACC_WIDTH + 1;  // Lane sum in the MSE block
  localparam int HSID_MSE_WIDTH     = 16;                  // Mean square error result
  localparam int HSID_BANDS_WIDTH   = 8;                   // Band count
  localparam int HSID_LIBRARY_WIDTH = 6;                   // Reference id
  localparam int HSID_LANE_DEPTH    = 3;                   // Diff, square and accumulate stages

  typedef logic [HSID_SAMPLE_WIDTH-1:0] sample_t;

  // One input word of one stream, slot i goes to lane i
  typedef struct packed {
    sample_t [HSID_LANES-1:0] sample;
  } band_word_t;

  // One lane slot with the vector marks
  typedef struct packed {
    sample_t a;
    sample_t b;
    logic    start;                                        // First word of a vector
    logic    last;                                         // Final word of a vector
    logic    valid;
  } lane_sample_t;

  // Lane result, valid for one cycle per vector
  typedef struct packed {
    logic [HSID_ACC_WIDTH-1:0] value;
    logic                      overflow;                   // Sticky carry out of the accumulator
    logic                      valid;
  } lane_acc_t;

  // Vector tag, captured on the last word
  typedef struct packed {
    logic [HSID_LIBRARY_WIDTH-1:0] ref_id;
    logic                          lib_last;               // Final entry of the library pass
    logic [HSID_BANDS_WIDTH-1:0]   bands;
  } vec_tag_t;

  // One mean square error per reference
  typedef struct packed {
    logic [HSID_MSE_WIDTH-1:0]     value;
    logic [HSID_LIBRARY_WIDTH-1:0] ref_id;
    logic                          overflow;
    logic                          lib_last;
  } mse_result_t;

  // Winner of one library pass
  typedef struct packed {
    logic [HSID_LIBRARY_WIDTH-1:0] ref_id;
    logic [HSID_MSE_WIDTH-1:0]     value;
    logic                          overflow;               // Best entry was overflowed too
  } match_t;

endpackage

// File: hsid_band_split.sv
`timescale 1ns/1ps

module hsid_band_split import hsid_pkg::*; (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                clear,
  input  logic                                band_valid,
  input  band_word_t                          band_a,
  input  band_word_t                          band_b,
  input  logic [HSID_BANDS_WIDTH-1:0]         hsp_bands,
  input  logic [HSID_LIBRARY_WIDTH-1:0]       hsp_ref,
  input  logic                                lib_last,
  output lane_sample_t [HSID_LANES-1:0]       lane,
  output vec_tag_t                            tag
);

  logic [HSID_BANDS_WIDTH-1:0] word_cnt;                // Words seen in the current vector
  logic [HSID_BANDS_WIDTH-1:0] words_per_vec;           // Bands spread over the lanes
  logic                        first_word;
  logic                        last_word;

  assign words_per_vec = hsp_bands / HSID_BANDS_WIDTH'(HSID_LANES);
  assign first_word    = (word_cnt == '0);
  assign last_word     = (word_cnt == words_per_vec - 1'b1);

  // Band counter, wraps on the last word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
    end else if (clear) begin
      word_cnt <= '0;                                   // Restart mid-vector
    end else if (band_valid) begin
      if (last_word) begin
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // Lane slots, one register stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane <= '0;
    end else if (clear) begin
      lane <= '0;
    end else begin
      for (int i = 0; i < HSID_LANES; i++) begin
        lane[i].a     <= band_a.sample[i];              // Slot i of stream A
        lane[i].b     <= band_b.sample[i];              // Slot i of stream B
        lane[i].start <= band_valid & first_word;       // Same marks on every lane
        lane[i].last  <= band_valid & last_word;
        lane[i].valid <= band_valid;
      end
    end
  end

  // Tag held until the next last word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag <= '0;
    end else if (clear) begin
      tag <= '0;
    end else if (band_valid && last_word) begin
      tag.ref_id   <= hsp_ref;
      tag.lib_last <= lib_last;
      tag.bands    <= hsp_bands;
    end
  end

endmodule

// File: hsid_sq_df_acc.sv
`timescale 1ns/1ps

module hsid_sq_df_acc import hsid_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         clear,
  input  lane_sample_t sample,
  output lane_acc_t    acc
);

  // Difference stage
  sample_t                   diff_q;                    // |a - b|
  logic                      diff_start;
  logic                      diff_last;
  logic                      diff_valid;
  // Square stage
  logic [HSID_SQ_WIDTH-1:0]  sq_q;
  logic                      sq_start;
  logic                      sq_last;
  logic                      sq_valid;
  // Accumulate stage
  logic [HSID_ACC_WIDTH-1:0] acc_q;
  logic                      of_q;                      // Sticky until the next start
  logic                      done_q;                    // Sum complete this cycle
  logic [HSID_ACC_WIDTH-1:0] sq_ext;
  logic [HSID_ACC_WIDTH:0]   sum_ext;                   // Carry in the top bit

  assign sq_ext  = HSID_ACC_WIDTH'(sq_q);
  assign sum_ext = {1'b0, acc_q} + {1'b0, sq_ext};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      diff_q     <= '0;
      diff_start <= 1'b0;
      diff_last  <= 1'b0;
      diff_valid <= 1'b0;
      sq_q       <= '0;
      sq_start   <= 1'b0;
      sq_last    <= 1'b0;
      sq_valid   <= 1'b0;
      acc_q      <= '0;
      of_q       <= 1'b0;
      done_q     <= 1'b0;
    end else if (clear) begin
      diff_q     <= '0;
      diff_start <= 1'b0;
      diff_last  <= 1'b0;
      diff_valid <= 1'b0;
      sq_q       <= '0;
      sq_start   <= 1'b0;
      sq_last    <= 1'b0;
      sq_valid   <= 1'b0;
      acc_q      <= '0;
      of_q       <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      diff_q     <= (sample.a > sample.b) ? sample.a - sample.b : sample.b - sample.a;
      diff_start <= sample.valid & sample.start;
      diff_last  <= sample.valid & sample.last;
      diff_valid <= sample.valid;
      sq_q       <= diff_q * diff_q;                    // Full 16 bit product
      sq_start   <= diff_start;
      sq_last    <= diff_last;
      sq_valid   <= diff_valid;
      if (sq_valid) begin
        if (sq_start) begin
          acc_q <= sq_ext;                              // New vector starts from its first square
          of_q  <= 1'b0;
        end else begin
          acc_q <= sum_ext[HSID_ACC_WIDTH-1:0];
          of_q  <= of_q | sum_ext[HSID_ACC_WIDTH];
        end
      end
      done_q <= sq_valid & sq_last;
    end
  end

  // Sum is final while done_q is high, the next start overwrites it
  assign acc.value    = acc_q;
  assign acc.overflow = of_q;
  assign acc.valid    = done_q;

endmodule

// File: hsid_mse.sv
`timescale 1ns/1ps

module hsid_mse import hsid_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           clear,
  input  lane_acc_t [HSID_LANES-1:0]     lane_acc,
  input  vec_tag_t                       tag,
  output mse_result_t                    mse,
  output logic                           mse_valid
);

  vec_tag_t [HSID_LANE_DEPTH-1:0] tag_dly;              // Tag follows the lane pipeline
  logic                           all_valid;
  logic                           any_of;
  logic [HSID_SUM_WIDTH-1:0]      lane_sum;
  // Sum stage
  logic [HSID_SUM_WIDTH-1:0]      sum_q;
  logic                           sum_of_q;             // OR of the lane flags
  vec_tag_t                       sum_tag_q;
  logic                           sum_valid_q;
  // Divide stage
  logic [HSID_SUM_WIDTH-1:0]      divisor;
  logic [HSID_SUM_WIDTH-1:0]      quot;

  // Lanes run in lock step, so all valids rise together
  always_comb begin
    all_valid = 1'b1;
    any_of    = 1'b0;
    lane_sum  = '0;
    for (int i = 0; i < HSID_LANES; i++) begin
      all_valid = all_valid & lane_acc[i].valid;
      any_of    = any_of | lane_acc[i].overflow;
      lane_sum  = lane_sum + HSID_SUM_WIDTH'(lane_acc[i].value);
    end
  end

  // Short vectors rewrite the tag before their sum arrives, so it is delayed here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_dly <= '0;
    end else if (clear) begin
      tag_dly <= '0;
    end else begin
      tag_dly <= {tag_dly[HSID_LANE_DEPTH-2:0], tag};
    end
  end

  // Sum stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q       <= '0;
      sum_of_q    <= 1'b0;
      sum_tag_q   <= '0;
      sum_valid_q <= 1'b0;
    end else if (clear) begin
      sum_q       <= '0;
      sum_of_q    <= 1'b0;
      sum_tag_q   <= '0;
      sum_valid_q <= 1'b0;
    end else begin
      if (all_valid) begin
        sum_q     <= lane_sum;
        sum_of_q  <= any_of;
        sum_tag_q <= tag_dly[HSID_LANE_DEPTH-1];        // Tag of this vector
      end
      sum_valid_q <= all_valid;
    end
  end

  assign divisor = HSID_SUM_WIDTH'(sum_tag_q.bands);
  assign quot    = sum_q / divisor;                     // Truncating divide

  // Divide stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mse       <= '0;
      mse_valid <= 1'b0;
    end else if (clear) begin
      mse       <= '0;
      mse_valid <= 1'b0;
    end else begin
      if (sum_valid_q) begin
        mse.value    <= quot[HSID_MSE_WIDTH-1:0];
        mse.ref_id   <= sum_tag_q.ref_id;
        mse.lib_last <= sum_tag_q.lib_last;
        // Sum carry, lane carry or a quotient wider than the result
        mse.overflow <= sum_q[HSID_SUM_WIDTH-1] | sum_of_q
                        | (|quot[HSID_SUM_WIDTH-1:HSID_MSE_WIDTH]);
      end
      mse_valid <= sum_valid_q;
    end
  end

endmodule

// File: hsid_min_search.sv
`timescale 1ns/1ps

module hsid_min_search import hsid_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clear,
  input  mse_result_t mse,
  input  logic        mse_valid,
  output match_t      match,
  output logic        match_valid
);

  match_t best_q;                                       // Best entry of the running pass
  logic   armed_q;                                      // best_q holds an entry of this pass
  match_t cand;
  match_t best_next;
  logic   cand_wins;

  assign cand.ref_id   = mse.ref_id;
  assign cand.value    = mse.value;
  assign cand.overflow = mse.overflow;

  // Overflowed results rank last, ties keep the earlier reference
  always_comb begin
    if (!armed_q) begin
      cand_wins = 1'b1;                                 // First entry of a pass
    end else if (best_q.overflow) begin
      cand_wins = !cand.overflow;
    end else begin
      cand_wins = !cand.overflow && (cand.value < best_q.value);
    end
    best_next = cand_wins ? cand : best_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      best_q      <= '0;
      armed_q     <= 1'b0;
      match       <= '0;
      match_valid <= 1'b0;
    end else if (clear) begin
      best_q      <= '0;
      armed_q     <= 1'b0;
      match       <= '0;
      match_valid <= 1'b0;
    end else begin
      match_valid <= 1'b0;
      if (mse_valid) begin
        if (mse.lib_last) begin
          match       <= best_next;                     // Pass done, report it
          match_valid <= 1'b1;
          armed_q     <= 1'b0;                          // Next result opens a new pass
        end else begin
          best_q  <= best_next;
          armed_q <= 1'b1;
        end
      end
    end
  end

endmodule

// File: hsid_top.sv
`timescale 1ns/1ps

module hsid_top import hsid_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clear,
  input  logic                          band_valid,
  input  band_word_t                    band_a,       // Pixel spectrum
  input  band_word_t                    band_b,       // Library spectrum
  input  logic [HSID_BANDS_WIDTH-1:0]   hsp_bands,
  input  logic [HSID_LIBRARY_WIDTH-1:0] hsp_ref,
  input  logic                          lib_last,     // High for the words of the final entry
  output mse_result_t                   mse,
  output logic                          mse_valid,
  output match_t                        match,
  output logic                          match_valid
);

  lane_sample_t [HSID_LANES-1:0] lane;                // Splitter to lanes
  lane_acc_t    [HSID_LANES-1:0] lane_acc;            // Lanes to MSE
  vec_tag_t                      tag;

  hsid_band_split u_split (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear      (clear),
    .band_valid (band_valid),
    .band_a     (band_a),
    .band_b     (band_b),
    .hsp_bands  (hsp_bands),
    .hsp_ref    (hsp_ref),
    .lib_last   (lib_last),
    .lane       (lane),
    .tag        (tag)
  );

  // One accumulator per sample slot
  for (genvar i = 0; i < HSID_LANES; i++) begin : g_lane
    hsid_sq_df_acc u_acc (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (clear),
      .sample (lane[i]),
      .acc    (lane_acc[i])
    );
  end

  hsid_mse u_mse (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .lane_acc  (lane_acc),
    .tag       (tag),
    .mse       (mse),
    .mse_valid (mse_valid)
  );

  hsid_min_search u_min (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (clear),
    .mse         (mse),
    .mse_valid   (mse_valid),
    .match       (match),
    .match_valid (match_valid)
  );

endmodule

// File: tb_hsid_top.sv
`timescale 1ns/1ps

module tb_hsid_top import hsid_pkg::*; ();

  localparam int MSE_LAT     = 6;                        // Last word to mse_valid
  localparam int MATCH_LAT   = 7;                        // Last word to match_valid
  localparam int NUM_TESTS   = 5;
  localparam int WORDS_TOTAL = 64 + 26 + 80 + 64 + 20;   // Words of tests 1 to 5
  localparam int CYCLE_LIMIT = WORDS_TOTAL + 50 * NUM_TESTS;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          clear;
  logic                          band_valid;
  band_word_t                    band_a;
  band_word_t                    band_b;
  logic [HSID_BANDS_WIDTH-1:0]   hsp_bands;
  logic [HSID_LIBRARY_WIDTH-1:0] hsp_ref;
  logic                          lib_last;
  mse_result_t                   mse;
  logic                          mse_valid;
  match_t                        match;
  logic                          match_valid;

  logic                 last_in;                         // Driven word closes a vector
  logic [MATCH_LAT-1:0] last_pipe = '0;                  // Last words by age in cycles
  logic [MATCH_LAT-1:0] lib_pipe = '0;                   // Same, library-last only
  sample_t              a_vec [256];                     // Pixel spectrum
  sample_t              b_vec [256];                     // Reference spectrum
  mse_result_t          mse_q [$];                       // Model results in flight
  match_t               match_q [$];
  match_t               best_m;                          // Model search state
  bit                   armed_m;
  match_t               last_match;
  logic [15:0]          lfsr = 16'd74;
  int                   err_cnt = 0;
  int                   mse_cnt = 0;
  int                   match_cnt = 0;
  int                   of_seen = 0;                     // Overflowed mse results
  int                   cycle_cnt = 0;
  int                   test_num = 0;
  int                   test_errs = 0;
  int                   failed_tests = 0;

  hsid_top u_dut (.*);

  always #2 clk = ~clk;

  // Expected strobes, shifted along with the DUT pipeline
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_pipe <= '0;
      lib_pipe  <= '0;
    end else if (clear) begin
      last_pipe <= '0;                                   // Pending vectors are dropped
      lib_pipe  <= '0;
    end else begin
      last_pipe <= {last_pipe[MATCH_LAT-2:0], band_valid & last_in};
      lib_pipe  <= {lib_pipe[MATCH_LAT-2:0], band_valid & last_in & lib_last};
    end
  end

  a_mse_strobe: assert property (@(posedge clk) mse_valid == last_pipe[MSE_LAT-1])
    else begin
      err_cnt++;
      $display("error %0t: mse_valid not %0d cycles after a last word", $time, MSE_LAT);
    end

  a_match_strobe: assert property (@(posedge clk) match_valid == lib_pipe[MATCH_LAT-1])
    else begin
      err_cnt++;
      $display("error %0t: match_valid not %0d cycles after a pass end", $time, MATCH_LAT);
    end

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      err_cnt++;
      $display("error %0t: %s", $time, msg);
    end
  endtask

  // Result values against the model queues
  always @(posedge clk) begin
    mse_result_t exp_r;
    match_t      exp_m;
    if (mse_valid) begin
      mse_cnt++;
      of_seen += int'(mse.overflow);
      if (mse_q.size() == 0) begin
        err_cnt++;
        $display("An mse result for ref %0d came with no vector pending", mse.ref_id);
      end else begin
        exp_r = mse_q.pop_front();
        check(mse == exp_r, $sformatf("ref %0d mse %0d of %0b, expected ref %0d mse %0d of %0b",
              mse.ref_id, mse.value, mse.overflow, exp_r.ref_id, exp_r.value, exp_r.overflow));
      end
    end
    if (match_valid) begin
      match_cnt++;
      last_match = match;
      if (match_q.size() == 0) begin
        err_cnt++;
        $display("A match for ref %0d came with no library pass pending", match.ref_id);
      end else begin
        exp_m = match_q.pop_front();
        check(match == exp_m, $sformatf("match ref %0d mse %0d, expected ref %0d mse %0d",
              match.ref_id, match.value, exp_m.ref_id, exp_m.value));
      end
    end
    if (clear) begin
      mse_q.delete();                                    // Nothing in flight survives
      match_q.delete();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("The run hit its limit of %0d cycles without finishing", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // Taps 16, 14, 13, 11
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};                         // One step per bit
    end
    return v;
  endfunction

  task automatic fill_random(input int bands, input bit pixel_too);
    for (int k = 0; k < bands; k++) begin
      if (pixel_too) a_vec[k] = sample_t'(rand_bits(HSID_SAMPLE_WIDTH));
      b_vec[k] = sample_t'(rand_bits(HSID_SAMPLE_WIDTH));
    end
  endtask

  task automatic fill_offset(input int bands, input sample_t mask);
    for (int k = 0; k < bands; k++) begin
      b_vec[k] = a_vec[k] ^ mask;                        // Fixed difference per band
    end
  endtask

  task automatic fill_flat(input int bands, input sample_t a, input sample_t b);
    for (int k = 0; k < bands; k++) begin
      a_vec[k] = a;
      b_vec[k] = b;
    end
  endtask

  // Expected mse and search update for one full vector
  task automatic model_vector(input int bands, input int ref_id, input bit lib);
    longint                  lane_tot [HSID_LANES];
    longint                  sum;
    longint                  quot;
    longint                  diff;
    mse_result_t             r;
    logic [HSID_MSE_WIDTH:0] key_new;
    logic [HSID_MSE_WIDTH:0] key_best;
    r        = '0;
    sum      = 0;
    lane_tot = '{default: 0};
    for (int k = 0; k < bands; k++) begin
      diff = longint'(a_vec[k]) - longint'(b_vec[k]);
      lane_tot[k % HSID_LANES] += diff * diff;          // Band k rides in slot k mod lanes
    end
    for (int i = 0; i < HSID_LANES; i++) begin
      if (lane_tot[i] >= (longint'(1) << HSID_ACC_WIDTH)) r.overflow = 1'b1;
      sum += lane_tot[i] % (longint'(1) << HSID_ACC_WIDTH);
    end
    sum = sum % (longint'(1) << (HSID_ACC_WIDTH + 1));  // Sum is one bit wider than a lane
    if (sum >= (longint'(1) << HSID_ACC_WIDTH)) r.overflow = 1'b1;
    quot = sum / bands;                                  // Truncating divide
    if (quot >= (longint'(1) << HSID_MSE_WIDTH)) r.overflow = 1'b1;
    r.value    = HSID_MSE_WIDTH'(quot);
    r.ref_id   = HSID_LIBRARY_WIDTH'(ref_id);
    r.lib_last = lib;
    mse_q.push_back(r);
    // Overflowed entries all share the worst rank
    key_new  = r.overflow ? '1 : {1'b0, r.value};
    key_best = best_m.overflow ? '1 : {1'b0, best_m.value};
    if (!armed_m || key_new < key_best) begin
      best_m = '{ref_id: r.ref_id, value: r.value, overflow: r.overflow};
    end
    if (lib) begin
      match_q.push_back(best_m);
      armed_m = 1'b0;                                    // Next result opens a pass
    end else begin
      armed_m = 1'b1;
    end
  endtask

  // Cut sends only that many words, with no result expected
  task automatic send_vector(input int bands, input int ref_id, input bit lib, input int cut = 0);
    int words;
    words = (cut > 0) ? cut : bands / HSID_LANES;
    for (int w = 0; w < words; w++) begin
      @(posedge clk);
      #1;
      band_valid = 1'b1;
      for (int i = 0; i < HSID_LANES; i++) begin
        band_a.sample[i] = a_vec[w * HSID_LANES + i];
        band_b.sample[i] = b_vec[w * HSID_LANES + i];
      end
      hsp_bands = HSID_BANDS_WIDTH'(bands);
      hsp_ref   = HSID_LIBRARY_WIDTH'(ref_id);
      lib_last  = lib;
      last_in   = (cut == 0) && (w == words - 1);
    end
    if (cut == 0) model_vector(bands, ref_id, lib);
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      band_valid = 1'b0;
      last_in    = 1'b0;
      lib_last   = 1'b0;
      clear      = 1'b0;
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    #1;
    band_valid = 1'b0;
    last_in    = 1'b0;
    clear      = 1'b1;
    armed_m    = 1'b0;                                   // Search state restarts too
  endtask

  task automatic drain();
    while (mse_q.size() != 0 || match_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_match(output match_t m);
    int start;
    start = match_cnt;
    while (match_cnt == start) begin
      @(posedge clk);
      #1;
    end
    m = last_match;
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (err_cnt != test_errs) failed_tests++;
    $display("test %0d %-28s %s", test_num, name, (err_cnt == test_errs) ? "pass" : "FAIL");
    test_errs = err_cnt;
  endtask

  initial begin
    match_t  m;
    int      mse_start;
    int      of_start;
    int      bands;
    sample_t tie_mask [4];
    tie_mask   = '{8'h10, 8'h01, 8'h04, 8'h01};          // Refs 31 and 33 tie at mse 1
    rst_n      = 1'b0;
    clear      = 1'b0;
    band_valid = 1'b0;
    band_a     = '0;
    band_b     = '0;
    hsp_bands  = '0;
    hsp_ref    = '0;
    lib_last   = 1'b0;
    last_in    = 1'b0;
    best_m     = '0;
    armed_m    = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    mse_start = mse_cnt;
    for (int v = 0; v < 8; v++) begin
      fill_random(16, 1'b1);
      send_vector(16, v, v == 7);
      drive_idle(1 + int'(rand_bits(2)));                // Gap of 1 to 4 cycles
    end
    drain();
    check(mse_cnt - mse_start == 8, "gapped vectors did not give 8 results");
    end_test("gapped vectors after reset");

    mse_start = mse_cnt;
    for (int v = 0; v < 5; v++) begin
      bands = (v % 3 == 0) ? 2 : ((v % 3 == 1) ? 8 : 32);
      fill_random(bands, 1'b1);
      send_vector(bands, 10 + v, v == 4);                // No idle between vectors
    end
    drive_idle(1);
    drain();
    check(mse_cnt - mse_start == 5, "back to back vectors did not give 5 results");
    end_test("back to back vectors");

    fill_random(16, 1'b1);
    for (int v = 0; v < 6; v++) begin
      if (v == 3) fill_offset(16, 8'h00);                // Ref 23 equals the pixel
      else fill_random(16, 1'b0);
      send_vector(16, 20 + v, v == 5);
      drive_idle(1);
    end
    wait_match(m);
    check(m.ref_id == 23 && m.value == 0 && !m.overflow, "identical reference not reported");
    for (int v = 0; v < 4; v++) begin
      fill_offset(16, tie_mask[v]);
      send_vector(16, 30 + v, v == 3);
      drive_idle(1);
    end
    wait_match(m);
    check(m.ref_id == 31 && m.value == 1, "tie did not keep the earlier reference");
    drain();
    end_test("library search");

    of_start = of_seen;
    fill_random(32, 1'b1);
    send_vector(32, 40, 1'b0);
    drive_idle(1);
    fill_flat(32, 8'hFF, 8'h00);                         // Largest difference on every band
    send_vector(32, 41, 1'b1);
    drive_idle(1);
    wait_match(m);
    check(m.ref_id == 40 && !m.overflow, "overflowed entry beat a valid one");
    send_vector(32, 42, 1'b0);
    drive_idle(1);
    fill_random(32, 1'b1);
    send_vector(32, 43, 1'b1);
    drive_idle(1);
    wait_match(m);
    check(m.ref_id == 43 && !m.overflow, "overflowed first entry was kept");
    drain();
    check(of_seen - of_start == 2, "overflow flag not raised on bright vectors");
    end_test("overflow");

    fill_random(16, 1'b1);
    send_vector(16, 50, 1'b0);
    send_vector(16, 51, 1'b1, 4);                        // Half a vector, then clear
    pulse_clear();
    mse_start = mse_cnt;
    drive_idle(10);
    check(mse_cnt == mse_start, "a result appeared after clear");
    fill_random(16, 1'b1);
    send_vector(16, 52, 1'b1);
    drive_idle(1);
    wait_match(m);
    check(m.ref_id == 52, "vector after clear not reported alone");
    drain();
    end_test("clear mid vector");

    $display("%0d tests, %0d failed, %0d errors", test_num, failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: build.f
hsid_pkg.sv
hsid_band_split.sv
hsid_sq_df_acc.sv
hsid_mse.sv
hsid_min_search.sv
hsid_top.sv
tb_hsid_top.sv

// File: Makefile
# Verilator build and run of the HSID classifier testbench

VERILATOR ?= verilator
TOP       ?= tb_hsid_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
